//--- logic/approx_mult_pkg.sv
package approx_mult_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    // operand word and operand RAM address
    localparam int DATA_W = 16;
    localparam int ADDR_W = 4;

    // scaled result and product RAM address
    localparam int RES_W      = 32;
    localparam int RES_ADDR_W = 3;

    // normalization stops at 7 shifts
    localparam int NORM_CNT_W = 3;

    // upper bits kept from each normalized operand
    localparam int TRUNC_W = 8;

    // scaling counter runs from s1 + s2 up to all ones
    localparam int SCALE_CNT_W = 4;

    ////////////////////////////////////////
    // controller states
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        IDLE,
        FETCH_A,
        FETCH_B,
        CAPTURE_B,
        NORMALIZE,
        MULTIPLY,
        SCALE,
        WRITE,
        FINISH
    } ctrl_state_t;

endpackage

//--- logic/step_counter.sv
module step_counter #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             init,
    input  logic             en,
    input  logic             load,
    input  logic [WIDTH-1:0] load_value,
    output logic [WIDTH-1:0] count,
    output logic             carry
);

    // init wins over load, load wins over count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (init) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (en) begin
            count <= count + WIDTH'(1);
        end
    end

    // high for the whole cycle the count sits at all ones
    assign carry = &count;

endmodule

//--- logic/shift_register.sv
module shift_register #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load,
    input  logic             shift_en,
    input  logic [WIDTH-1:0] load_value,
    output logic [WIDTH-1:0] value
);

    // load first, then a one-bit left shift with zero fill
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value <= '0;
        end else if (load) begin
            value <= load_value;
        end else if (shift_en) begin
            value <= {value[WIDTH-2:0], 1'b0};
        end
    end

endmodule

//--- logic/operand_ram.sv
module operand_ram (
    input  logic                               clk,
    input  logic                               wr,
    input  logic [approx_mult_pkg::ADDR_W-1:0] wr_addr,
    input  logic [approx_mult_pkg::DATA_W-1:0] wr_data,
    input  logic [approx_mult_pkg::ADDR_W-1:0] rd_addr,
    output logic [approx_mult_pkg::DATA_W-1:0] rd_data
);

    // even words hold operand A, odd words operand B
    logic [approx_mult_pkg::DATA_W-1:0] mem [2**approx_mult_pkg::ADDR_W];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // data shows up one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- logic/product_ram.sv
module product_ram (
    input  logic                                   clk,
    input  logic                                   wr,
    input  logic [approx_mult_pkg::RES_ADDR_W-1:0] wr_addr,
    input  logic [approx_mult_pkg::RES_W-1:0]      wr_data,
    input  logic [approx_mult_pkg::RES_ADDR_W-1:0] rd_addr,
    output logic [approx_mult_pkg::RES_W-1:0]      rd_data
);

    // one entry per operand pair
    logic [approx_mult_pkg::RES_W-1:0] mem [2**approx_mult_pkg::RES_ADDR_W];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // asynchronous read port
    assign rd_data = mem[rd_addr];

endmodule

//--- logic/approx_mult_datapath.sv
module approx_mult_datapath (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   pair_init,
    input  logic                                   pair_next,
    input  logic                                   fetch_b,
    input  logic                                   load_a,
    input  logic                                   load_b,
    input  logic                                   norm_init,
    input  logic                                   norm_en,
    input  logic                                   mult_load,
    input  logic                                   scale_en,
    input  logic [approx_mult_pkg::DATA_W-1:0]     op_data,
    output logic [approx_mult_pkg::ADDR_W-1:0]     op_addr,
    output logic [approx_mult_pkg::RES_ADDR_W-1:0] res_addr,
    output logic [approx_mult_pkg::RES_W-1:0]      res_data,
    output logic                                   norm_done,
    output logic                                   scale_done,
    output logic                                   last_pair
);

    logic [approx_mult_pkg::RES_ADDR_W-1:0]  pair_count;
    logic [approx_mult_pkg::DATA_W-1:0]      op_a;
    logic [approx_mult_pkg::DATA_W-1:0]      op_b;
    logic [approx_mult_pkg::NORM_CNT_W-1:0]  shift_a;
    logic [approx_mult_pkg::NORM_CNT_W-1:0]  shift_b;
    logic                                    shift_a_max;
    logic                                    shift_b_max;
    logic                                    norm_a_en;
    logic                                    norm_b_en;
    logic [2*approx_mult_pkg::TRUNC_W-1:0]   product;
    logic [approx_mult_pkg::SCALE_CNT_W-1:0] scale_sum;

    ////////////////////////////////////////
    // pair addressing
    ////////////////////////////////////////

    step_counter #(.WIDTH(approx_mult_pkg::RES_ADDR_W)) pair_cnt_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .init       (pair_init),
        .en         (pair_next),
        .load       (1'b0),
        .load_value ({approx_mult_pkg::RES_ADDR_W{1'b0}}),
        .count      (pair_count),
        .carry      (last_pair)
    );

    // low bit picks B
    assign op_addr  = {pair_count, fetch_b};
    assign res_addr = pair_count;

    ////////////////////////////////////////
    // normalization
    ////////////////////////////////////////

    // shift while the msb is clear and the cap is not reached
    assign norm_a_en = norm_en && !op_a[approx_mult_pkg::DATA_W-1] && !shift_a_max;
    assign norm_b_en = norm_en && !op_b[approx_mult_pkg::DATA_W-1] && !shift_b_max;

    shift_register #(.WIDTH(approx_mult_pkg::DATA_W)) op_a_reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load_a),
        .shift_en   (norm_a_en),
        .load_value (op_data),
        .value      (op_a)
    );

    shift_register #(.WIDTH(approx_mult_pkg::DATA_W)) op_b_reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load_b),
        .shift_en   (norm_b_en),
        .load_value (op_data),
        .value      (op_b)
    );

    step_counter #(.WIDTH(approx_mult_pkg::NORM_CNT_W)) norm_a_cnt_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .init       (norm_init),
        .en         (norm_a_en),
        .load       (1'b0),
        .load_value ({approx_mult_pkg::NORM_CNT_W{1'b0}}),
        .count      (shift_a),
        .carry      (shift_a_max)
    );

    step_counter #(.WIDTH(approx_mult_pkg::NORM_CNT_W)) norm_b_cnt_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .init       (norm_init),
        .en         (norm_b_en),
        .load       (1'b0),
        .load_value ({approx_mult_pkg::NORM_CNT_W{1'b0}}),
        .count      (shift_b),
        .carry      (shift_b_max)
    );

    assign norm_done = (op_a[approx_mult_pkg::DATA_W-1] || shift_a_max) &&
                       (op_b[approx_mult_pkg::DATA_W-1] || shift_b_max);

    ////////////////////////////////////////
    // truncated multiply and scaling
    ////////////////////////////////////////

    assign product = op_a[approx_mult_pkg::DATA_W-1 -: approx_mult_pkg::TRUNC_W] *
                     op_b[approx_mult_pkg::DATA_W-1 -: approx_mult_pkg::TRUNC_W];

    // s1 + s2 is at most 14
    assign scale_sum = approx_mult_pkg::SCALE_CNT_W'(shift_a) +
                       approx_mult_pkg::SCALE_CNT_W'(shift_b);

    // counts from s1 + s2 to all ones, 16 - (s1 + s2) shifts
    step_counter #(.WIDTH(approx_mult_pkg::SCALE_CNT_W)) scale_cnt_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .init       (pair_init),
        .en         (scale_en),
        .load       (mult_load),
        .load_value (scale_sum),
        .count      (),
        .carry      (scale_done)
    );

    shift_register #(.WIDTH(approx_mult_pkg::RES_W)) scale_reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (mult_load),
        .shift_en   (scale_en),
        .load_value ({{(approx_mult_pkg::RES_W-2*approx_mult_pkg::TRUNC_W){1'b0}}, product}),
        .value      (res_data)
    );

endmodule

//--- logic/approx_mult_controller.sv
module approx_mult_controller (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic norm_done,
    input  logic scale_done,
    input  logic last_pair,
    output logic busy,
    output logic done,
    output logic pair_init,
    output logic pair_next,
    output logic fetch_b,
    output logic load_a,
    output logic load_b,
    output logic norm_init,
    output logic norm_en,
    output logic mult_load,
    output logic scale_en,
    output logic res_wr
);

    approx_mult_pkg::ctrl_state_t state;
    approx_mult_pkg::ctrl_state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= approx_mult_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////
    // sequencing and strobes
    ////////////////////////////////////////

    always_comb begin
        state_next = state;
        pair_init  = 1'b0;
        pair_next  = 1'b0;
        fetch_b    = 1'b0;
        load_a     = 1'b0;
        load_b     = 1'b0;
        norm_init  = 1'b0;
        norm_en    = 1'b0;
        mult_load  = 1'b0;
        scale_en   = 1'b0;
        res_wr     = 1'b0;
        busy       = 1'b1;
        done       = 1'b0;

        unique case (state)
            approx_mult_pkg::IDLE: begin
                busy      = 1'b0;
                pair_init = 1'b1;
                if (start) begin
                    state_next = approx_mult_pkg::FETCH_A;
                end
            end
            approx_mult_pkg::FETCH_A: begin
                state_next = approx_mult_pkg::FETCH_B;
            end
            // A word is on the read port now
            approx_mult_pkg::FETCH_B: begin
                fetch_b    = 1'b1;
                load_a     = 1'b1;
                state_next = approx_mult_pkg::CAPTURE_B;
            end
            approx_mult_pkg::CAPTURE_B: begin
                load_b     = 1'b1;
                norm_init  = 1'b1;
                state_next = approx_mult_pkg::NORMALIZE;
            end
            approx_mult_pkg::NORMALIZE: begin
                norm_en = 1'b1;
                if (norm_done) begin
                    state_next = approx_mult_pkg::MULTIPLY;
                end
            end
            approx_mult_pkg::MULTIPLY: begin
                mult_load  = 1'b1;
                state_next = approx_mult_pkg::SCALE;
            end
            // shift also on the carry cycle
            approx_mult_pkg::SCALE: begin
                scale_en = 1'b1;
                if (scale_done) begin
                    state_next = approx_mult_pkg::WRITE;
                end
            end
            approx_mult_pkg::WRITE: begin
                res_wr = 1'b1;
                if (last_pair) begin
                    state_next = approx_mult_pkg::FINISH;
                end else begin
                    pair_next  = 1'b1;
                    state_next = approx_mult_pkg::FETCH_A;
                end
            end
            // engine is idle here, so a new start is taken
            approx_mult_pkg::FINISH: begin
                busy      = 1'b0;
                done      = 1'b1;
                pair_init = 1'b1;
                if (start) begin
                    state_next = approx_mult_pkg::FETCH_A;
                end else begin
                    state_next = approx_mult_pkg::IDLE;
                end
            end
            default: begin
                busy       = 1'b0;
                state_next = approx_mult_pkg::IDLE;
            end
        endcase
    end

endmodule

//--- logic/approx_mult_top.sv
module approx_mult_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start,
    output logic                                   busy,
    output logic                                   done,
    input  logic                                   ld_wr,
    input  logic [approx_mult_pkg::ADDR_W-1:0]     ld_addr,
    input  logic [approx_mult_pkg::DATA_W-1:0]     ld_data,
    input  logic [approx_mult_pkg::RES_ADDR_W-1:0] rd_addr,
    output logic [approx_mult_pkg::RES_W-1:0]      rd_data
);

    logic                                   pair_init;
    logic                                   pair_next;
    logic                                   fetch_b;
    logic                                   load_a;
    logic                                   load_b;
    logic                                   norm_init;
    logic                                   norm_en;
    logic                                   mult_load;
    logic                                   scale_en;
    logic                                   res_wr;
    logic                                   norm_done;
    logic                                   scale_done;
    logic                                   last_pair;
    logic [approx_mult_pkg::ADDR_W-1:0]     op_addr;
    logic [approx_mult_pkg::DATA_W-1:0]     op_data;
    logic [approx_mult_pkg::RES_ADDR_W-1:0] res_addr;
    logic [approx_mult_pkg::RES_W-1:0]      res_data;

    approx_mult_controller ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .norm_done  (norm_done),
        .scale_done (scale_done),
        .last_pair  (last_pair),
        .busy       (busy),
        .done       (done),
        .pair_init  (pair_init),
        .pair_next  (pair_next),
        .fetch_b    (fetch_b),
        .load_a     (load_a),
        .load_b     (load_b),
        .norm_init  (norm_init),
        .norm_en    (norm_en),
        .mult_load  (mult_load),
        .scale_en   (scale_en),
        .res_wr     (res_wr)
    );

    approx_mult_datapath dp_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pair_init  (pair_init),
        .pair_next  (pair_next),
        .fetch_b    (fetch_b),
        .load_a     (load_a),
        .load_b     (load_b),
        .norm_init  (norm_init),
        .norm_en    (norm_en),
        .mult_load  (mult_load),
        .scale_en   (scale_en),
        .op_data    (op_data),
        .op_addr    (op_addr),
        .res_addr   (res_addr),
        .res_data   (res_data),
        .norm_done  (norm_done),
        .scale_done (scale_done),
        .last_pair  (last_pair)
    );

    operand_ram op_ram_i (
        .clk     (clk),
        .wr      (ld_wr),
        .wr_addr (ld_addr),
        .wr_data (ld_data),
        .rd_addr (op_addr),
        .rd_data (op_data)
    );

    product_ram res_ram_i (
        .clk     (clk),
        .wr      (res_wr),
        .wr_addr (res_addr),
        .wr_data (res_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- test/approx_mult_properties.sv
module approx_mult_properties (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic done
);

    ////////////////////////////////////////
    // done and busy protocol
    ////////////////////////////////////////

    done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
        else $error("busy was high together with done");

    // IDLE right after reset
    reset_quiet: assert property (@(posedge clk) !rst_n |=> !busy && !done)
        else $error("busy or done high right after reset");

    start_raises_busy: assert property (@(posedge clk) disable iff (!rst_n)
                                        start && !busy |=> busy)
        else $error("start while idle did not raise busy");

endmodule

bind approx_mult_top approx_mult_properties props_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .busy  (busy),
    .done  (done)
);

//--- test/approx_mult_tb.sv
module approx_mult_tb;

    localparam int PAIRS   = 8;
    localparam int BATCHES = 3;
    localparam int ROWS    = BATCHES * PAIRS;

    // 40 cycles per pair plus operand loads, start and readback per batch
    localparam int MAX_CYCLES = ROWS * 40 + BATCHES * (3 * PAIRS + 8) + 100;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   start;
    logic                                   busy;
    logic                                   done;
    logic                                   ld_wr;
    logic [approx_mult_pkg::ADDR_W-1:0]     ld_addr;
    logic [approx_mult_pkg::DATA_W-1:0]     ld_data;
    logic [approx_mult_pkg::RES_ADDR_W-1:0] rd_addr;
    logic [approx_mult_pkg::RES_W-1:0]      rd_data;

    // first batch is hand-picked
    logic [15:0] picked_a [PAIRS] = '{16'h8000, 16'h00FF, 16'h0000, 16'hABCD,
                                      16'hFFFF, 16'h0001, 16'h4000, 16'h1234};
    logic [15:0] picked_b [PAIRS] = '{16'h0100, 16'h0003, 16'h1234, 16'h0000,
                                      16'hFFFF, 16'h0001, 16'h2000, 16'h00F0};

    logic [15:0] tab_a [ROWS];
    logic [15:0] tab_b [ROWS];
    logic [31:0] tab_p [ROWS];
    logic [31:0] lfsr;
    int          cycles      = 0;
    int          checks      = 0;
    int          errors      = 0;
    int          done_pulses = 0;

    approx_mult_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .ld_wr   (ld_wr),
        .ld_addr (ld_addr),
        .ld_data (ld_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the engine never finished", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rst_n && done) begin
            done_pulses = done_pulses + 1;
        end
    end

    ////////////////////////////////////////
    // reference model and random source
    ////////////////////////////////////////

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    // leading zeros, never more than 7
    function automatic int capped_lzc(input logic [15:0] v);
        int n;
        n = 0;
        while (n < 7 && !v[15]) begin
            v = v << 1;
            n = n + 1;
        end
        return n;
    endfunction

    function automatic logic [31:0] model_product(input logic [15:0] a, input logic [15:0] b);
        int          sa;
        int          sb;
        logic [15:0] na;
        logic [15:0] nb;
        sa = capped_lzc(a);
        sb = capped_lzc(b);
        na = a << sa;
        nb = b << sb;
        return (32'(na[15:8]) * 32'(nb[15:8])) << (16 - sa - sb);
    endfunction

    task automatic fill_table();
        logic [15:0] ra;
        logic [15:0] rb;
        logic [15:0] sh;
        int          i;
        for (i = 0; i < ROWS; i++) begin
            if (i < PAIRS) begin
                ra = picked_a[i];
                rb = picked_b[i];
            end else begin
                // random right shift spreads the leading zero count past the cap
                draw_bits(16, ra);
                draw_bits(4, sh);
                ra = ra >> sh[3:0];
                draw_bits(16, rb);
                draw_bits(4, sh);
                rb = rb >> sh[3:0];
            end
            tab_a[i] = ra;
            tab_b[i] = rb;
            tab_p[i] = model_product(ra, rb);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // batch sequencing
    ////////////////////////////////////////

    task automatic load_batch(input int batch);
        int k;
        for (k = 0; k < PAIRS; k++) begin
            @(posedge clk);
            ld_wr   <= 1'b1;
            ld_addr <= approx_mult_pkg::ADDR_W'(2 * k);
            ld_data <= tab_a[batch * PAIRS + k];
            @(posedge clk);
            ld_addr <= approx_mult_pkg::ADDR_W'(2 * k + 1);
            ld_data <= tab_b[batch * PAIRS + k];
        end
        @(posedge clk);
        ld_wr <= 1'b0;
    endtask

    task automatic run_batch(input bit extra_start);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value("busy after start", 32'(busy), 32'd1);
        // a start while busy has to be ignored
        if (extra_start) begin
            repeat (3) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
        check_value("busy with done", 32'(busy), 32'd0);
    endtask

    task automatic read_results(input int batch);
        int k;
        for (k = 0; k < PAIRS; k++) begin
            @(posedge clk);
            rd_addr <= approx_mult_pkg::RES_ADDR_W'(k);
            @(negedge clk);
            check_value($sformatf("product %0d of batch %0d", k, batch), rd_data,
                        tab_p[batch * PAIRS + k]);
        end
    endtask

    initial begin
        int b;
        clk     = 1'b0;
        rst_n   = 1'b0;
        start   = 1'b0;
        ld_wr   = 1'b0;
        ld_addr = '0;
        ld_data = '0;
        rd_addr = '0;
        lfsr    = 32'h933cfa18;
        fill_table();

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("busy after reset", 32'(busy), 32'd0);
        check_value("done after reset", 32'(done), 32'd0);

        for (b = 0; b < BATCHES; b++) begin
            load_batch(b);
            run_batch(b == 1);
            read_results(b);
            check_value("done pulse count", 32'(done_pulses), 32'(b + 1));
        end

        $display("checks: %0d, errors: %0d, done pulses: %0d", checks, errors, done_pulses);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/approx_mult_pkg.sv
logic/step_counter.sv
logic/shift_register.sv
logic/operand_ram.sv
logic/product_ram.sv
logic/approx_mult_datapath.sv
logic/approx_mult_controller.sv
logic/approx_mult_top.sv
test/approx_mult_properties.sv
test/approx_mult_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module approx_mult_tb -f vlog.f -Mdir obj_dir -o approx_mult_sim
	./obj_dir/approx_mult_sim | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
